//--- Core.f
+incdir+rtl
rtl/CoreTypes.sv
rtl/FetchUnit.sv
rtl/RegisterFile.sv
rtl/DecodeStage.sv
rtl/ExecutionStage.sv
rtl/RegisterWriteStage.sv
rtl/Core.sv
sim/Core_asserts.sv
sim/CoreTb.sv

//--- Makefile
# Verilator lint, simulation and clean for the core

VERILATOR ?= verilator
FILELIST  ?= Core.f
RTL_TOP   ?= Core
TB_TOP    ?= CoreTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/CoreTb.sv
/*
 * CoreTb
 * Runs random programs through the core from a Wishbone memory model
 * with random wait states and checks serial output and commit PC
 * against an in-order reference model.
 */
`timescale 1ns/1ps
`include "core_config.svh"

module CoreTb;
    localparam int CLK_PERIOD = 8;
    localparam int PROG_MAX = 128;
    localparam int ALU_LEN = 40;
    localparam int FWD_LEN = 40;
    localparam int IMM_LEN = 30;
    localparam int ORDER_LEN = 24;
    // Seed ADDIs, two spacer NOPs and eight closing OUTs per program
    localparam int EXTRA_LEN = 17;
    localparam int TOTAL_INSTR = ALU_LEN + FWD_LEN + IMM_LEN + ORDER_LEN + 4 * EXTRA_LEN + 8;
    localparam int WATCHDOG_NS = TOTAL_INSTR * 7 * CLK_PERIOD + 4000;

    logic                        clk;
    logic                        rst;
    logic [`CORE_DATA_WIDTH-1:0] wbDatIn;
    logic                        wbAck;
    logic                        wbCyc;
    logic                        wbStb;
    logic [`CORE_DATA_WIDTH-1:0] wbAdr;
    logic                        serialWE;
    logic [`CORE_DATA_WIDTH-1:0] serialWriteData;
    logic [`CORE_DATA_WIDTH-1:0] lastCommittedPC;

    integer seed = 36;
    logic [31:0] progMem [PROG_MAX];
    int progLen = 0;
    logic [31:0] expOut [$];
    logic [31:0] expPC [$];
    logic [31:0] ackAddrs [$];
    string curTest;
    int testErrors;
    int passCount;
    int failCount;

    Core Core_inst (
        .clk             (clk),
        .rst             (rst),
        .wbDatIn         (wbDatIn),
        .wbAck           (wbAck),
        .wbCyc           (wbCyc),
        .wbStb           (wbStb),
        .wbAdr           (wbAdr),
        .serialWE        (serialWE),
        .serialWriteData (serialWriteData),
        .lastCommittedPC (lastCommittedPC)
    );

    bind Core Core_asserts coreAssertsInst (
        .clk      (clk),
        .rst      (rst),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbAdr    (wbAdr),
        .wbAck    (wbAck),
        .serialWE (serialWE)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int randBelow(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic [31:0] encode(input CoreTypes::OpCode op, input int rd,
                                           input int rs1, input int rs2,
                                           input logic [15:0] imm);
        logic [31:0] w;
        w = '0;
        w[`CORE_OP_HI:`CORE_OP_LO] = op;
        w[`CORE_RD_HI:`CORE_RD_LO] = rd[2:0];
        w[`CORE_RS1_HI:`CORE_RS1_LO] = rs1[2:0];
        w[`CORE_RS2_HI:`CORE_RS2_LO] = rs2[2:0];
        w[`CORE_IMM_WIDTH-1:0] = imm;
        return w;
    endfunction

    function automatic logic [31:0] memWord(input logic [31:0] addr);
        logic [31:0] index;
        index = addr >> 2;
        if (index < progLen) begin
            return progMem[index];
        end
        // Past the program end, NOPs that vary with the address
        return {4'h0, addr[27:0] ^ {24'd0, addr[31:28]}};
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
            testErrors++;
        end
    endtask

    // Slave acks each request after 1 to 4 cycles
    initial begin : memoryModel
        int waitLeft;
        bit pending;
        wbAck = 1'b0;
        wbDatIn = '0;
        pending = 1'b0;
        waitLeft = 0;
        forever begin
            @(posedge clk);
            #1;
            wbAck = 1'b0;
            if (rst || !(wbCyc && wbStb)) begin
                pending = 1'b0;
            end else begin
                if (!pending) begin
                    pending = 1'b1;
                    waitLeft = randBelow(4);
                end
                if (waitLeft == 0) begin
                    wbAck = 1'b1;
                    wbDatIn = memWord(wbAdr);
                    ackAddrs.push_back(wbAdr);
                    pending = 1'b0;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && serialWE) begin
            if (expOut.size() == 0) begin
                $display("%s: serial write of 0x%08h with no OUT pending", curTest,
                         serialWriteData);
                testErrors++;
            end else begin
                checkValue(curTest, expOut.pop_front(), serialWriteData);
                checkValue(curTest, expPC.pop_front(), lastCommittedPC);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns before all tests finished", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic appendInstr(input logic [31:0] w);
        progMem[progLen] = w;
        progLen++;
    endtask

    // Mode 0 independent sources, 1 dense chains, 2 negative ADDI and r0 writes
    task automatic buildProgram(input int mode, input int len);
        int recentA;
        int recentB;
        int rd;
        int rs1;
        int rs2;
        int pick;
        CoreTypes::OpCode op;
        logic [15:0] imm;
        progLen = 0;
        recentA = 0;
        recentB = 0;
        for (int r = 1; r < `CORE_REG_NUM; r++) begin
            appendInstr(encode(CoreTypes::OP_ADDI, r, 0, 0, 16'(randBelow(65536))));
        end
        appendInstr(encode(CoreTypes::OP_NOP, 0, 0, 0, 16'd0));
        appendInstr(encode(CoreTypes::OP_NOP, 0, 0, 0, 16'd0));
        for (int i = 0; i < len; i++) begin
            pick = randBelow(8);
            rd = 1 + randBelow(7);
            rs1 = randBelow(8);
            rs2 = randBelow(8);
            imm = 16'(randBelow(65536));
            case (mode)
                0: begin
                    op = (pick == 7) ? CoreTypes::OP_OUT :
                         (pick == 6) ? CoreTypes::OP_NOP : CoreTypes::OpCode'(1 + pick % 5);
                    while (rs1 != 0 && (rs1 == recentA || rs1 == recentB)) begin
                        rs1 = randBelow(8);
                    end
                    while (rs2 != 0 && (rs2 == recentA || rs2 == recentB)) begin
                        rs2 = randBelow(8);
                    end
                end
                1: begin
                    op = (pick >= 6) ? CoreTypes::OP_OUT :
                         (pick == 5) ? CoreTypes::OP_ADDI : CoreTypes::OpCode'(1 + pick);
                    rs1 = (pick % 2 == 0) ? recentA : recentB;
                    rs2 = recentA;
                end
                default: begin
                    op = (pick < 4) ? CoreTypes::OP_ADDI :
                         (pick < 7) ? CoreTypes::OP_OUT : CoreTypes::OP_ADD;
                    rd = (randBelow(4) == 0) ? 0 : rd;
                    imm[15] = 1'b1;
                end
            endcase
            appendInstr(encode(op, rd, rs1, rs2, imm));
            recentB = recentA;
            recentA = (op == CoreTypes::OP_OUT || op == CoreTypes::OP_NOP) ? 0 : rd;
        end
        for (int r = 0; r < `CORE_REG_NUM; r++) begin
            appendInstr(encode(CoreTypes::OP_OUT, 0, r, 0, 16'd0));
        end
    endtask

    task automatic runModel();
        logic [31:0] regs [`CORE_REG_NUM];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] result;
        bit writes;
        int rd;
        expOut.delete();
        expPC.delete();
        for (int r = 0; r < `CORE_REG_NUM; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < progLen; i++) begin
            w = progMem[i];
            rd = w[`CORE_RD_HI:`CORE_RD_LO];
            a = regs[w[`CORE_RS1_HI:`CORE_RS1_LO]];
            b = regs[w[`CORE_RS2_HI:`CORE_RS2_LO]];
            imm = {{16{w[15]}}, w[15:0]};
            result = '0;
            writes = 1'b1;
            case (CoreTypes::OpCode'(w[`CORE_OP_HI:`CORE_OP_LO]))
                CoreTypes::OP_ADD:  result = a + b;
                CoreTypes::OP_SUB:  result = a - b;
                CoreTypes::OP_AND:  result = a & b;
                CoreTypes::OP_OR:   result = a | b;
                CoreTypes::OP_XOR:  result = a ^ b;
                CoreTypes::OP_ADDI: result = a + imm;
                CoreTypes::OP_OUT: begin
                    expOut.push_back(a);
                    expPC.push_back(`CORE_RESET_PC + i * `CORE_PC_STEP);
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes && rd != 0) begin
                regs[rd] = result;
            end
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            passCount++;
            $display("[PASS] %s", curTest);
        end else begin
            failCount++;
            $display("[FAIL] %s with %0d errors", curTest, testErrors);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        ackAddrs.delete();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            // Outputs settle after the first reset edge
            if (i > 0) begin
                checkValue(curTest, 32'd0, wbCyc);
                checkValue(curTest, 32'd0, serialWE);
                checkValue(curTest, `CORE_RESET_PC, lastCommittedPC);
            end
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
    endtask

    task automatic runProgram(input string name, input int mode, input int len);
        int cycles;
        int limit;
        startTest(name);
        buildProgram(mode, len);
        runModel();
        applyReset();
        limit = progLen * 7 + 40;
        cycles = 0;
        while (expOut.size() != 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (expOut.size() != 0) begin
            $display("%s: timed out with %0d serial writes still missing", name, expOut.size());
            testErrors++;
        end
    endtask

    task automatic resetTest();
        int cycles;
        startTest("resetTest");
        progLen = 0;
        expOut.delete();
        expPC.delete();
        applyReset();
        @(negedge clk);
        checkValue(curTest, 32'd0, wbCyc);
        checkValue(curTest, 32'd0, serialWE);
        cycles = 0;
        while (!wbCyc && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!wbCyc) begin
            $display("%s: no bus request raised after reset", curTest);
            testErrors++;
        end else begin
            checkValue(curTest, `CORE_RESET_PC, wbAdr);
        end
        finishTest();
    endtask

    task automatic fetchOrderTest();
        runProgram("fetchOrderTest", 0, ORDER_LEN);
        if (ackAddrs.size() == 0) begin
            $display("%s: no fetch was acknowledged", curTest);
            testErrors++;
        end else begin
            checkValue(curTest, `CORE_RESET_PC, ackAddrs[0]);
            for (int i = 1; i < ackAddrs.size(); i++) begin
                checkValue(curTest, ackAddrs[i - 1] + `CORE_PC_STEP, ackAddrs[i]);
            end
        end
        finishTest();
    endtask

    initial begin : mainSequence
        rst = 1'b1;
        curTest = "init";
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        resetTest();
        fetchOrderTest();
        runProgram("aluTest", 0, ALU_LEN);
        finishTest();
        runProgram("forwardTest", 1, FWD_LEN);
        finishTest();
        runProgram("immZeroTest", 2, IMM_LEN);
        finishTest();
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : CoreTb

//--- sim/Core_asserts.sv
/*
 * Core_asserts
 * Wishbone request rules and serial strobe width on the core ports
 */
`timescale 1ns/1ps
`include "core_config.svh"

module Core_asserts (
    input logic                        clk,
    input logic                        rst,
    input logic                        wbCyc,
    input logic                        wbStb,
    input logic [`CORE_DATA_WIDTH-1:0] wbAdr,
    input logic                        wbAck,
    input logic                        serialWE
);
    property cycMatchesStb;
        @(posedge clk) disable iff (rst) wbCyc == wbStb;
    endproperty

    // Classic cycle holds until acked
    property requestHeld;
        @(posedge clk) disable iff (rst)
            (wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr));
    endproperty

    property serialSinglePulse;
        @(posedge clk) disable iff (rst) serialWE |=> !serialWE;
    endproperty

    cycStbCheck: assert property (cycMatchesStb)
        else $error("wbCyc and wbStb differ");
    requestHeldCheck: assert property (requestHeld)
        else $error("Request dropped or address changed before ack");
    serialPulseCheck: assert property (serialSinglePulse)
        else $error("serialWE high on two consecutive cycles");

endmodule : Core_asserts

//--- rtl/Core.sv
/*
 * Core
 * Four-stage in-order core: fetch over Wishbone, decode with register
 * read, execute with bypass, and register write with serial output.
 */
`timescale 1ns/1ps
`include "core_config.svh"

module Core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`CORE_DATA_WIDTH-1:0] wbDatIn,
    input  logic                        wbAck,
    output logic                        wbCyc,
    output logic                        wbStb,
    output logic [`CORE_DATA_WIDTH-1:0] wbAdr,
    output logic                        serialWE,
    output logic [`CORE_DATA_WIDTH-1:0] serialWriteData,
    output logic [`CORE_DATA_WIDTH-1:0] lastCommittedPC
);
    logic                            fetchValid;
    logic [`CORE_DATA_WIDTH-1:0]     fetchInstr;
    logic [`CORE_DATA_WIDTH-1:0]     fetchPC;

    logic [`CORE_REG_ADDR_WIDTH-1:0] rdAddrA;
    logic [`CORE_REG_ADDR_WIDTH-1:0] rdAddrB;
    logic [`CORE_DATA_WIDTH-1:0]     rdDataA;
    logic [`CORE_DATA_WIDTH-1:0]     rdDataB;

    logic                            decValid;
    CoreTypes::OpCode                decOp;
    logic [`CORE_REG_ADDR_WIDTH-1:0] decRd;
    logic [`CORE_REG_ADDR_WIDTH-1:0] decRs1;
    logic [`CORE_REG_ADDR_WIDTH-1:0] decRs2;
    logic [`CORE_DATA_WIDTH-1:0]     decOpA;
    logic [`CORE_DATA_WIDTH-1:0]     decOpB;
    logic [`CORE_DATA_WIDTH-1:0]     decImm;
    logic [`CORE_DATA_WIDTH-1:0]     decPC;

    logic                            exValid;
    CoreTypes::OpCode                exOp;
    logic [`CORE_REG_ADDR_WIDTH-1:0] exRd;
    logic [`CORE_DATA_WIDTH-1:0]     exResult;
    logic [`CORE_DATA_WIDTH-1:0]     exPC;

    logic                            wrEn;
    logic [`CORE_REG_ADDR_WIDTH-1:0] wrAddr;
    logic [`CORE_DATA_WIDTH-1:0]     wrData;

    FetchUnit fetchInst (
        .clk        (clk),
        .rst        (rst),
        .wbDatIn    (wbDatIn),
        .wbAck      (wbAck),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbAdr      (wbAdr),
        .fetchValid (fetchValid),
        .fetchInstr (fetchInstr),
        .fetchPC    (fetchPC)
    );

    RegisterFile regFileInst (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    DecodeStage decodeInst (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchInstr (fetchInstr),
        .fetchPC    (fetchPC),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .decValid   (decValid),
        .decOp      (decOp),
        .decRd      (decRd),
        .decRs1     (decRs1),
        .decRs2     (decRs2),
        .decOpA     (decOpA),
        .decOpB     (decOpB),
        .decImm     (decImm),
        .decPC      (decPC)
    );

    ExecutionStage execInst (
        .clk      (clk),
        .rst      (rst),
        .decValid (decValid),
        .decOp    (decOp),
        .decRd    (decRd),
        .decRs1   (decRs1),
        .decRs2   (decRs2),
        .decOpA   (decOpA),
        .decOpB   (decOpB),
        .decImm   (decImm),
        .decPC    (decPC),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .exValid  (exValid),
        .exOp     (exOp),
        .exRd     (exRd),
        .exResult (exResult),
        .exPC     (exPC)
    );

    RegisterWriteStage writeInst (
        .clk             (clk),
        .rst             (rst),
        .exValid         (exValid),
        .exOp            (exOp),
        .exRd            (exRd),
        .exResult        (exResult),
        .exPC            (exPC),
        .wrEn            (wrEn),
        .wrAddr          (wrAddr),
        .wrData          (wrData),
        .serialWE        (serialWE),
        .serialWriteData (serialWriteData),
        .lastCommittedPC (lastCommittedPC)
    );

endmodule : Core

//--- rtl/RegisterWriteStage.sv
/*
 * RegisterWriteStage
 * Writes ALU results back, commits every valid instruction and
 * drives the serial port for OUT.
 */
`timescale 1ns/1ps
`include "core_config.svh"

module RegisterWriteStage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            exValid,
    input  CoreTypes::OpCode                exOp,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] exRd,
    input  logic [`CORE_DATA_WIDTH-1:0]     exResult,
    input  logic [`CORE_DATA_WIDTH-1:0]     exPC,
    output logic                            wrEn,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] wrAddr,
    output logic [`CORE_DATA_WIDTH-1:0]     wrData,
    output logic                            serialWE,
    output logic [`CORE_DATA_WIDTH-1:0]     serialWriteData,
    output logic [`CORE_DATA_WIDTH-1:0]     lastCommittedPC
);
    logic writesReg;
    logic isOut;

    // NOP and OUT leave the registers alone
    always_comb begin
        case (exOp)
            CoreTypes::OP_ADD,
            CoreTypes::OP_SUB,
            CoreTypes::OP_AND,
            CoreTypes::OP_OR,
            CoreTypes::OP_XOR,
            CoreTypes::OP_ADDI: writesReg = 1'b1;
            default:            writesReg = 1'b0;
        endcase
    end

    assign isOut  = exValid && (exOp == CoreTypes::OP_OUT);
    assign wrEn   = exValid && writesReg;
    assign wrAddr = exRd;
    assign wrData = exResult;

    always_ff @(posedge clk) begin
        if (rst) begin
            serialWE        <= 1'b0;
            serialWriteData <= '0;
            lastCommittedPC <= `CORE_RESET_PC;
        end else begin
            serialWE <= isOut;
            if (isOut) begin
                serialWriteData <= exResult;
            end
            if (exValid) begin
                lastCommittedPC <= exPC;
            end
        end
    end

endmodule : RegisterWriteStage

//--- rtl/ExecutionStage.sv
/*
 * ExecutionStage
 * Integer ALU with bypass from the write-back stage. Result is
 * registered together with op, destination and PC.
 */
`timescale 1ns/1ps
`include "core_config.svh"

module ExecutionStage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            decValid,
    input  CoreTypes::OpCode                decOp,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] decRd,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] decRs1,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] decRs2,
    input  logic [`CORE_DATA_WIDTH-1:0]     decOpA,
    input  logic [`CORE_DATA_WIDTH-1:0]     decOpB,
    input  logic [`CORE_DATA_WIDTH-1:0]     decImm,
    input  logic [`CORE_DATA_WIDTH-1:0]     decPC,
    input  logic                            wrEn,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] wrAddr,
    input  logic [`CORE_DATA_WIDTH-1:0]     wrData,
    output logic                            exValid,
    output CoreTypes::OpCode                exOp,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] exRd,
    output logic [`CORE_DATA_WIDTH-1:0]     exResult,
    output logic [`CORE_DATA_WIDTH-1:0]     exPC
);
    logic [`CORE_DATA_WIDTH-1:0] opA;
    logic [`CORE_DATA_WIDTH-1:0] opB;
    logic [`CORE_DATA_WIDTH-1:0] aluOut;

    // Bypass the instruction one ahead; r0 is never forwarded
    assign opA = (wrEn && wrAddr == decRs1 && decRs1 != '0) ? wrData : decOpA;
    assign opB = (wrEn && wrAddr == decRs2 && decRs2 != '0) ? wrData : decOpB;

    always_comb begin
        case (decOp)
            CoreTypes::OP_ADD:  aluOut = opA + opB;
            CoreTypes::OP_SUB:  aluOut = opA - opB;
            CoreTypes::OP_AND:  aluOut = opA & opB;
            CoreTypes::OP_OR:   aluOut = opA | opB;
            CoreTypes::OP_XOR:  aluOut = opA ^ opB;
            CoreTypes::OP_ADDI: aluOut = opA + decImm;
            CoreTypes::OP_OUT:  aluOut = opA;
            default:            aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid <= 1'b0;
        end else begin
            exValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        exOp     <= decOp;
        exRd     <= decRd;
        exResult <= aluOut;
        exPC     <= decPC;
    end

endmodule : ExecutionStage

//--- rtl/DecodeStage.sv
/*
 * DecodeStage
 * Splits the fetched word into fields, reads both source registers
 * and registers the decoded instruction for execute.
 */
`timescale 1ns/1ps
`include "core_config.svh"

module DecodeStage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            fetchValid,
    input  logic [`CORE_DATA_WIDTH-1:0]     fetchInstr,
    input  logic [`CORE_DATA_WIDTH-1:0]     fetchPC,
    input  logic [`CORE_DATA_WIDTH-1:0]     rdDataA,
    input  logic [`CORE_DATA_WIDTH-1:0]     rdDataB,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] rdAddrA,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] rdAddrB,
    output logic                            decValid,
    output CoreTypes::OpCode                decOp,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] decRd,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] decRs1,
    output logic [`CORE_REG_ADDR_WIDTH-1:0] decRs2,
    output logic [`CORE_DATA_WIDTH-1:0]     decOpA,
    output logic [`CORE_DATA_WIDTH-1:0]     decOpB,
    output logic [`CORE_DATA_WIDTH-1:0]     decImm,
    output logic [`CORE_DATA_WIDTH-1:0]     decPC
);
    logic [3:0] opField;
    CoreTypes::OpCode op;
    logic [`CORE_DATA_WIDTH-1:0] immExt;

    assign opField = fetchInstr[`CORE_OP_HI:`CORE_OP_LO];
    assign rdAddrA = fetchInstr[`CORE_RS1_HI:`CORE_RS1_LO];
    assign rdAddrB = fetchInstr[`CORE_RS2_HI:`CORE_RS2_LO];
    assign immExt  = {{(`CORE_DATA_WIDTH - `CORE_IMM_WIDTH){fetchInstr[`CORE_IMM_WIDTH-1]}},
                      fetchInstr[`CORE_IMM_WIDTH-1:0]};

    // Unused encodings behave as NOP
    always_comb begin
        if (opField > CoreTypes::OP_OUT) begin
            op = CoreTypes::OP_NOP;
        end else begin
            op = CoreTypes::OpCode'(opField);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else begin
            decValid <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        decOp  <= op;
        decRd  <= fetchInstr[`CORE_RD_HI:`CORE_RD_LO];
        decRs1 <= rdAddrA;
        decRs2 <= rdAddrB;
        decOpA <= rdDataA;
        decOpB <= rdDataB;
        decImm <= immExt;
        decPC  <= fetchPC;
    end

endmodule : DecodeStage

//--- rtl/RegisterFile.sv
/*
 * RegisterFile
 * Integer registers with two combinational read ports and one write
 * port. Same-cycle writes are visible on reads; r0 reads zero.
 */
`timescale 1ns/1ps
`include "core_config.svh"

module RegisterFile (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] rdAddrA,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] rdAddrB,
    input  logic                           wrEn,
    input  logic [`CORE_REG_ADDR_WIDTH-1:0] wrAddr,
    input  logic [`CORE_DATA_WIDTH-1:0]     wrData,
    output logic [`CORE_DATA_WIDTH-1:0]     rdDataA,
    output logic [`CORE_DATA_WIDTH-1:0]     rdDataB
);
    logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_REG_NUM];

    function automatic logic [`CORE_DATA_WIDTH-1:0] readPort(
        input logic [`CORE_REG_ADDR_WIDTH-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wrEn && wrAddr == addr) begin
            // Write-through for the instruction two ahead
            return wrData;
        end
        return regs[addr];
    endfunction

    assign rdDataA = readPort(rdAddrA);
    assign rdDataB = readPort(rdAddrB);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule : RegisterFile

//--- rtl/FetchUnit.sv
/*
 * FetchUnit
 * Wishbone classic read master for instruction words. Holds the PC,
 * issues one read per instruction and hands each acked word to decode.
 */
`timescale 1ns/1ps
`include "core_config.svh"

module FetchUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`CORE_DATA_WIDTH-1:0] wbDatIn,
    input  logic                        wbAck,
    output logic                        wbCyc,
    output logic                        wbStb,
    output logic [`CORE_DATA_WIDTH-1:0] wbAdr,
    output logic                        fetchValid,
    output logic [`CORE_DATA_WIDTH-1:0] fetchInstr,
    output logic [`CORE_DATA_WIDTH-1:0] fetchPC
);
    CoreTypes::FetchState state;
    logic [`CORE_DATA_WIDTH-1:0] pc;
    logic ackTaken;

    assign wbCyc = (state == CoreTypes::FETCH_REQ);
    assign wbStb = wbCyc;
    assign wbAdr = pc;
    assign ackTaken = wbCyc && wbAck;

    always_ff @(posedge clk) begin
        if (rst) begin
            // Idle through reset, request follows on release
            state      <= CoreTypes::FETCH_GAP;
            pc         <= `CORE_RESET_PC;
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= 1'b0;
            case (state)
                CoreTypes::FETCH_REQ: begin
                    if (wbAck) begin
                        state      <= CoreTypes::FETCH_GAP;
                        pc         <= pc + `CORE_PC_STEP;
                        fetchValid <= 1'b1;
                    end
                end
                default: begin
                    state <= CoreTypes::FETCH_REQ;
                end
            endcase
        end
    end

    // Word and its address held for the gap cycle
    always_ff @(posedge clk) begin
        if (ackTaken) begin
            fetchInstr <= wbDatIn;
            fetchPC    <= pc;
        end
    end

endmodule : FetchUnit

//--- rtl/CoreTypes.sv
/*
 * CoreTypes
 * Opcode and fetch state encodings shared by the core stages
 */
package CoreTypes;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_OUT  = 4'd7
    } OpCode;

    // Bus request pending, or the one idle cycle after an ack
    typedef enum logic [1:0] {
        FETCH_REQ = 2'd0,
        FETCH_GAP = 2'd1
    } FetchState;

endpackage : CoreTypes

//--- rtl/core_config.svh
/*
 * Core configuration
 * Datapath widths, register count, reset PC and the bit fields
 * of the 32-bit instruction word
 */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define CORE_DATA_WIDTH     32
`define CORE_REG_NUM        8
`define CORE_REG_ADDR_WIDTH 3
`define CORE_RESET_PC       32'h0000_0000
`define CORE_PC_STEP        32'd4

// Instruction fields
`define CORE_OP_HI          31
`define CORE_OP_LO          28
`define CORE_RD_HI          27
`define CORE_RD_LO          25
`define CORE_RS1_HI         24
`define CORE_RS1_LO         22
`define CORE_RS2_HI         21
`define CORE_RS2_LO         19
`define CORE_IMM_WIDTH      16

`endif
